// File: bus_pkg.sv
// cache bus types
// one request struct goes from a requester toward memory and one
// response struct comes back, shared by the sequencer, the arbiter,
// the memory and the scalar port

`default_nettype none

package bus_pkg;

  // byte address on the cache bus
  typedef logic [31:0] addr_t;

  // one data word
  typedef logic [31:0] word_t;

  // request toward memory, 70 bits
  // held unchanged by the requester until busy drops
  typedef struct packed {
    addr_t       addr;
    logic        ren;
    logic        wen;
    word_t       wdata;
    // one bit per byte lane, bit 0 is wdata[7:0]
    logic [3:0]  byte_en;
  } bus_req_t;

  // response back to the requester, 33 bits
  // the cycle with busy low completes the access
  typedef struct packed {
    // only meaningful for a read in the completing cycle
    word_t rdata;
    logic  busy;
  } bus_rsp_t;

endpackage

`default_nettype wire

// File: cache_memory.sv
// behavioural cache memory
// word-addressed storage with byte enables, each access is answered
// after LATENCY consecutive request cycles

`timescale 1ns/1ps
`default_nettype none

module cache_memory #(
  parameter int LATENCY   = 2,
  parameter int MEM_WORDS = 256
) (
  input  logic              CLK,
  input  logic              nRST,
  input  bus_pkg::bus_req_t req,
  output bus_pkg::bus_rsp_t rsp
);

  localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
  localparam int CNT_W = $clog2(LATENCY + 1);

  bus_pkg::word_t   mem_q [MEM_WORDS];
  logic [CNT_W-1:0] cnt_q;

  logic             access;
  logic             done;
  logic [29:0]      word_addr;
  logic [IDX_W-1:0] idx;

  assign access = req.ren | req.wen;
  // LATENCY-th consecutive request cycle finishes the access
  assign done   = access && (cnt_q == CNT_W'(LATENCY - 1));

  // word index wraps at the array size
  assign word_addr = req.addr[31:2];
  assign idx       = IDX_W'(word_addr % MEM_WORDS);

  // busy cycle counter
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      cnt_q <= '0;
    end else if (!access || done) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // storage, cleared at reset
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem_q[i] <= '0;
      end
    end else if (done && req.wen) begin
      // only selected byte lanes change
      for (int b = 0; b < 4; b++) begin
        if (req.byte_en[b]) begin
          mem_q[idx][8*b +: 8] <= req.wdata[8*b +: 8];
        end
      end
    end
  end

  // read data shows up only in the completing cycle of a read
  assign rsp.rdata = (done && req.ren) ? mem_q[idx] : '0;
  assign rsp.busy  = !done;

endmodule

`default_nettype wire

// File: lsu_mem_asserts.sv
// bus protocol and arbitration checks
// bound to the memory arbiter, watches both sides and the memory port

`timescale 1ns/1ps
`default_nettype none

module lsu_mem_asserts (
  input logic              CLK,
  input logic              nRST,
  input logic [1:0]        grant,
  input bus_pkg::bus_rsp_t scalar_rsp,
  input bus_pkg::bus_rsp_t vector_rsp,
  input bus_pkg::bus_req_t mem_req,
  input bus_pkg::bus_rsp_t mem_rsp
);

  // encoding of the arbiter grant register
  localparam logic [1:0] GRANT_VEC = 2'd1;
  localparam logic [1:0] GRANT_SCA = 2'd2;

  // a side without the grant only ever sees busy
  ungranted_busy: assert property (@(posedge CLK) disable iff (!nRST)
    (grant == GRANT_SCA || scalar_rsp.busy) && (grant == GRANT_VEC || vector_rsp.busy))
    else $error("busy dropped at a side that does not hold the grant");

  // never two completions in one cycle
  one_completion: assert property (@(posedge CLK) disable iff (!nRST)
    scalar_rsp.busy || vector_rsp.busy)
    else $error("both sides saw busy low in the same cycle");

  // request held unchanged until memory finishes it
  req_stable: assert property (@(posedge CLK) disable iff (!nRST)
    (mem_req.ren || mem_req.wen) && mem_rsp.busy |=> $stable(mem_req))
    else $error("memory request changed while memory was busy");

endmodule

bind memory_arbiter lsu_mem_asserts u_asserts (
  .CLK        (CLK),
  .nRST       (nRST),
  .grant      (state_q),
  .scalar_rsp (scalar_rsp),
  .vector_rsp (vector_rsp),
  .mem_req    (mem_req),
  .mem_rsp    (mem_rsp)
);

`default_nettype wire

// File: lsu_mem_subsystem.sv
// load/store memory subsystem
// vector sequencer and scalar port share one cache memory through
// the arbiter, memory timing set here

`timescale 1ns/1ps
`default_nettype none

module lsu_mem_subsystem #(
  parameter int LATENCY   = 2,
  parameter int MEM_WORDS = 256
) (
  input  logic                   CLK,
  input  logic                   nRST,
  input  bus_pkg::bus_req_t      scalar_req,
  output bus_pkg::bus_rsp_t      scalar_rsp,
  input  logic                   cmd_valid,
  output logic                   cmd_ready,
  input  vmem_pkg::vmem_cmd_t    cmd,
  output logic                   res_valid,
  input  logic                   res_ready,
  output vmem_pkg::vmem_result_t res
);

  // sequencer to arbiter
  bus_pkg::bus_req_t vec_req;
  bus_pkg::bus_rsp_t vec_rsp;
  // arbiter to memory
  bus_pkg::bus_req_t mem_req;
  bus_pkg::bus_rsp_t mem_rsp;

  vector_mem_sequencer u_seq (
    .CLK       (CLK),
    .nRST      (nRST),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .cmd       (cmd),
    .res_valid (res_valid),
    .res_ready (res_ready),
    .res       (res),
    .bus_req   (vec_req),
    .bus_rsp   (vec_rsp)
  );

  memory_arbiter u_arb (
    .CLK        (CLK),
    .nRST       (nRST),
    .scalar_req (scalar_req),
    .scalar_rsp (scalar_rsp),
    .vector_req (vec_req),
    .vector_rsp (vec_rsp),
    .mem_req    (mem_req),
    .mem_rsp    (mem_rsp)
  );

  cache_memory #(
    .LATENCY   (LATENCY),
    .MEM_WORDS (MEM_WORDS)
  ) u_mem (
    .CLK  (CLK),
    .nRST (nRST),
    .req  (mem_req),
    .rsp  (mem_rsp)
  );

endmodule

`default_nettype wire

// File: memory_arbiter.sv
// memory arbiter
// shares one cache bus between the scalar load/store port and the
// vector sequencer, vector wins from idle and the grant alternates
// when both sides wait so neither can starve the other

`timescale 1ns/1ps
`default_nettype none

module memory_arbiter (
  input  logic              CLK,
  input  logic              nRST,
  input  bus_pkg::bus_req_t scalar_req,
  output bus_pkg::bus_rsp_t scalar_rsp,
  input  bus_pkg::bus_req_t vector_req,
  output bus_pkg::bus_rsp_t vector_rsp,
  output bus_pkg::bus_req_t mem_req,
  input  bus_pkg::bus_rsp_t mem_rsp
);

  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_VEC,
    ARB_SCA
  } arb_state_t;

  arb_state_t state_q;
  arb_state_t state_d;

  logic vec_pend;
  logic sca_pend;

  // a side is waiting when it raises either strobe
  assign vec_pend = vector_req.ren | vector_req.wen;
  assign sca_pend = scalar_req.ren | scalar_req.wen;

  // grant register
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state_q <= ARB_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // next grant
  always_comb begin
    state_d = state_q;
    case (state_q)
      ARB_IDLE: begin
        // vector side first
        if (vec_pend) begin
          state_d = ARB_VEC;
        end else if (sca_pend) begin
          state_d = ARB_SCA;
        end
      end
      ARB_VEC: begin
        // on completion hand over to scalar if it waits
        if (!mem_rsp.busy) begin
          state_d = sca_pend ? ARB_SCA : ARB_IDLE;
        end
      end
      ARB_SCA: begin
        if (!mem_rsp.busy) begin
          state_d = vec_pend ? ARB_VEC : ARB_IDLE;
        end
      end
      default: begin
        state_d = ARB_IDLE;
      end
    endcase
  end

  // steering by the registered grant
  always_comb begin
    // nothing granted means a quiet bus and busy at both sides
    mem_req    = '0;
    scalar_rsp = '{rdata: '0, busy: 1'b1};
    vector_rsp = '{rdata: '0, busy: 1'b1};
    case (state_q)
      ARB_VEC: begin
        mem_req    = vector_req;
        vector_rsp = mem_rsp;
      end
      ARB_SCA: begin
        mem_req    = scalar_req;
        scalar_rsp = mem_rsp;
      end
      default: begin
        mem_req = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f verilog.f \
  --top-module tb_lsu_mem_subsystem -o sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi
out=$(./obj_dir/sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi
if echo "$out" | grep -q "ALL TESTS PASSED"; then
  exit 0
fi
exit 1

// File: tb_lsu_mem_subsystem.sv
// testbench for the load/store memory subsystem
// scalar and vector traffic checked against a shadow of the memory

`timescale 1ns/1ps
`default_nettype none

module tb_lsu_mem_subsystem;

  localparam int LATENCY   = 2;
  localparam int MEM_WORDS = 256;
  localparam int VLEN      = vmem_pkg::VLEN;
  // cycle limit of every wait loop
  localparam int TMO       = 200;

  logic                   CLK = 1'b0;
  logic                   nRST;
  bus_pkg::bus_req_t      scalar_req;
  bus_pkg::bus_rsp_t      scalar_rsp;
  logic                   cmd_valid;
  logic                   cmd_ready;
  vmem_pkg::vmem_cmd_t    cmd;
  logic                   res_valid;
  logic                   res_ready;
  vmem_pkg::vmem_result_t res;

  int                     err_val = 0;
  int                     err_tmo = 0;
  bus_pkg::word_t         shadow [MEM_WORDS];
  // expected read data in completion order
  bus_pkg::word_t         rd_exp [$];
  vmem_pkg::vmem_result_t res_exp [$];
  bus_pkg::word_t         exp_w;
  vmem_pkg::vmem_result_t exp_r;

  lsu_mem_subsystem #(
    .LATENCY   (LATENCY),
    .MEM_WORDS (MEM_WORDS)
  ) dut (.*);

  always #10 CLK = ~CLK;

  // word index wrapping at the memory size
  function automatic int widx(input bus_pkg::addr_t a);
    return int'((a >> 2) % MEM_WORDS);
  endfunction

  // reference gather of a strided load from the shadow
  function automatic vmem_pkg::vmem_result_t ref_vload(input bus_pkg::addr_t base,
                                                       input logic [31:0] stride);
    vmem_pkg::vmem_result_t r;
    for (int i = 0; i < VLEN; i++) begin
      r.data[i] = shadow[widx(base + 32'(i) * stride)];
    end
    return r;
  endfunction

  // random aligned base with a stride between -16 and +16 words
  function automatic vmem_pkg::vmem_cmd_t rand_cmd(input logic st);
    vmem_pkg::vmem_cmd_t c;
    c.store  = st;
    c.base   = $urandom & ~32'h3;
    c.stride = 32'((int'($urandom % 33) - 16) * 4);
    for (int i = 0; i < VLEN; i++) begin
      c.data[i] = $urandom;
    end
    return c;
  endfunction

  // compare completed reads with the queued expectations
  always @(posedge CLK) begin
    if (nRST && scalar_req.ren && !scalar_rsp.busy) begin
      exp_w = (rd_exp.size() > 0) ? rd_exp.pop_front() : 32'hxxxx_xxxx;
      assert (scalar_rsp.rdata === exp_w) else begin
        $display("** Error scalar_rsp.rdata addr=%h got=%h exp=%h",
                 scalar_req.addr, scalar_rsp.rdata, exp_w);
        err_val++;
      end
    end
    if (nRST && res_valid && res_ready) begin
      exp_r = (res_exp.size() > 0) ? res_exp.pop_front() : 'x;
      assert (res === exp_r) else begin
        $display("** Error res got=%h exp=%h", res, exp_r);
        err_val++;
      end
    end
  end

  // wait for res_valid (sel high) or cmd_ready (sel low) at a rising edge
  task automatic wait_for(input bit sel);
    int n = 0;
    do begin
      @(posedge CLK);
      n++;
    end while (!(sel ? res_valid : cmd_ready) && n < TMO);
    if (!(sel ? res_valid : cmd_ready)) begin
      $display("timeout waiting for %s", sel ? "res_valid" : "cmd_ready");
      err_tmo++;
    end
  endtask

  // one uncontended scalar access whose busy drops LATENCY+1 edges after the raise
  task automatic scalar_access(input logic wr, input bus_pkg::addr_t a,
                               input bus_pkg::word_t d, input logic [3:0] be);
    int n = 0;
    @(negedge CLK);
    scalar_req = '{addr: a, ren: !wr, wen: wr, wdata: d, byte_en: be};
    for (int b = 0; b < 4; b++) begin
      if (wr && be[b]) begin
        shadow[widx(a)][8*b +: 8] = d[8*b +: 8];
      end
    end
    if (!wr) begin
      rd_exp.push_back(shadow[widx(a)]);
    end
    do begin
      @(posedge CLK);
      n++;
    end while (scalar_rsp.busy && n < TMO);
    assert (n == LATENCY + 1) else begin
      $display("scalar access at %h took %0d cycles instead of %0d", a, n, LATENCY + 1);
      err_val++;
    end
    @(negedge CLK);
    scalar_req = '0;
  endtask

  // hand one command over and return on the falling edge after acceptance
  task automatic vector_issue(input vmem_pkg::vmem_cmd_t c);
    @(negedge CLK);
    cmd_valid = 1'b1;
    cmd       = c;
    for (int i = 0; i < VLEN; i++) begin
      if (c.store) begin
        shadow[widx(c.base + 32'(i) * c.stride)] = c.data[i];
      end
    end
    if (!c.store) begin
      res_exp.push_back(ref_vload(c.base, c.stride));
    end
    wait_for(1'b0);
    @(negedge CLK);
    cmd_valid = 1'b0;
  endtask

  initial begin
    vmem_pkg::vmem_cmd_t    c;
    vmem_pkg::vmem_result_t held;
    bus_pkg::addr_t         addrs [8];
    int                     n;
    int                     sca_cyc;
    int                     hold;
    logic                   done;
    void'($urandom(36656));
    nRST       = 1'b0;
    scalar_req = '0;
    cmd_valid  = 1'b0;
    cmd        = '0;
    res_ready  = 1'b1;
    for (int i = 0; i < MEM_WORDS; i++) begin
      shadow[i] = '0;
    end
    repeat (10) @(posedge CLK);
    @(negedge CLK);
    nRST = 1'b1;
    // idle outputs straight after reset
    @(posedge CLK);
    assert (!res_valid && cmd_ready && scalar_rsp.busy) else begin
      $display("** Error after reset res_valid=%h cmd_ready=%h scalar_rsp.busy=%h",
               res_valid, cmd_ready, scalar_rsp.busy);
      err_val++;
    end
    // scalar writes with random byte enables and then read back
    for (int i = 0; i < 8; i++) begin
      addrs[i] = $urandom & ~32'h3;
      scalar_access(1'b1, addrs[i], $urandom, 4'($urandom));
    end
    for (int i = 0; i < 8; i++) begin
      scalar_access(1'b0, addrs[i], '0, 4'hf);
    end
    // vector store read back by scalar loads and by a vector load
    c = rand_cmd(1'b1);
    vector_issue(c);
    wait_for(1'b0);
    for (int i = 0; i < VLEN; i++) begin
      scalar_access(1'b0, c.base + 32'(i) * c.stride, '0, 4'hf);
    end
    c.store = 1'b0;
    for (int k = 0; k < 3; k++) begin
      vector_issue(c);
      wait_for(1'b1);
      wait_for(1'b0);
      c = rand_cmd(1'b0);
    end
    // scalar read raised as element 0 starts so the vector wins and then hands over
    c = rand_cmd(1'b0);
    vector_issue(c);
    scalar_req = '{addr: addrs[0], ren: 1'b1, wen: 1'b0, wdata: '0, byte_en: 4'hf};
    rd_exp.push_back(shadow[widx(addrs[0])]);
    n       = 0;
    sca_cyc = 0;
    do begin
      @(posedge CLK);
      n++;
      if (scalar_req.ren && !scalar_rsp.busy) begin
        sca_cyc = n;
      end
      done = res_valid;
      @(negedge CLK);
      if (sca_cyc != 0) begin
        scalar_req = '0;
      end
    end while (!done && n < TMO);
    scalar_req = '0;
    // scalar waits exactly one vector element and still beats the last one
    // the last element completes one cycle before res_valid
    assert (done && sca_cyc == 2 * LATENCY + 1 && sca_cyc < n - 1) else begin
      $display("contended scalar read done after %0d cycles, vector result after %0d",
               sca_cyc, n);
      err_val++;
    end
    wait_for(1'b0);
    // result held under back-pressure
    @(negedge CLK);
    res_ready = 1'b0;
    vector_issue(rand_cmd(1'b0));
    wait_for(1'b1);
    held = res;
    hold = 2 + int'($urandom % 8);
    repeat (hold) begin
      @(posedge CLK);
      assert (res_valid && res == held && !cmd_ready) else begin
        $display("** Error under back-pressure res_valid=%h res=%h cmd_ready=%h held=%h",
                 res_valid, res, cmd_ready, held);
        err_val++;
      end
    end
    @(negedge CLK);
    res_ready = 1'b1;
    wait_for(1'b1);
    wait_for(1'b0);
    $display("errors: %0d value, %0d timeout", err_val, err_tmo);
    if (err_val == 0 && err_tmo == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: vector_mem_sequencer.sv
// vector memory sequencer
// turns one strided vector command into VLEN word accesses on the
// cache bus, one after another, and gathers load data into a
// result that is handed off with valid/ready

`timescale 1ns/1ps
`default_nettype none

module vector_mem_sequencer (
  input  logic                   CLK,
  input  logic                   nRST,
  input  logic                   cmd_valid,
  output logic                   cmd_ready,
  input  vmem_pkg::vmem_cmd_t    cmd,
  output logic                   res_valid,
  input  logic                   res_ready,
  output vmem_pkg::vmem_result_t res,
  output bus_pkg::bus_req_t      bus_req,
  input  bus_pkg::bus_rsp_t      bus_rsp
);

  localparam int IDX_W = (vmem_pkg::VLEN > 1) ? $clog2(vmem_pkg::VLEN) : 1;

  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_RUN,
    SEQ_RESULT
  } seq_state_t;

  seq_state_t             state_q;
  logic [IDX_W-1:0]       idx_q;
  // latched command and running element address
  vmem_pkg::vmem_cmd_t    cmd_q;
  bus_pkg::addr_t         addr_q;
  vmem_pkg::vmem_result_t res_q;

  logic cmd_fire;
  logic elem_done;
  logic last_elem;

  // handshake and step conditions
  assign cmd_fire  = cmd_valid && cmd_ready;
  assign elem_done = (state_q == SEQ_RUN) && !bus_rsp.busy;
  assign last_elem = (idx_q == IDX_W'(vmem_pkg::VLEN - 1));

  // control state
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state_q <= SEQ_IDLE;
      idx_q   <= '0;
    end else begin
      case (state_q)
        SEQ_IDLE: begin
          if (cmd_fire) begin
            state_q <= SEQ_RUN;
            idx_q   <= '0;
          end
        end
        SEQ_RUN: begin
          if (elem_done) begin
            if (last_elem) begin
              // stores finish here, loads wait for the result handshake
              state_q <= cmd_q.store ? SEQ_IDLE : SEQ_RESULT;
              idx_q   <= '0;
            end else begin
              idx_q <= idx_q + 1'b1;
            end
          end
        end
        SEQ_RESULT: begin
          if (res_ready) begin
            state_q <= SEQ_IDLE;
          end
        end
        default: begin
          state_q <= SEQ_IDLE;
        end
      endcase
    end
  end

  // payload registers
  always_ff @(posedge CLK) begin
    if (cmd_fire) begin
      cmd_q  <= cmd;
      addr_q <= cmd.base;
    end else if (elem_done) begin
      // next element address is one stride further on
      addr_q <= addr_q + cmd_q.stride;
    end
    // gather read data as each load element completes
    if (elem_done && !cmd_q.store) begin
      res_q.data[idx_q] <= bus_rsp.rdata;
    end
  end

  // bus request, held until busy drops
  always_comb begin
    bus_req = '0;
    if (state_q == SEQ_RUN) begin
      bus_req.addr    = addr_q;
      bus_req.ren     = !cmd_q.store;
      bus_req.wen     = cmd_q.store;
      bus_req.wdata   = cmd_q.data[idx_q];
      // full-word elements only
      bus_req.byte_en = 4'hf;
    end
  end

  // handshake outputs
  assign cmd_ready = (state_q == SEQ_IDLE);
  assign res_valid = (state_q == SEQ_RESULT);
  assign res       = res_q;

endmodule

`default_nettype wire

// File: verilog.f
bus_pkg.sv
vmem_pkg.sv
vector_mem_sequencer.sv
memory_arbiter.sv
cache_memory.sv
lsu_mem_subsystem.sv
lsu_mem_asserts.sv
tb_lsu_mem_subsystem.sv

// File: vmem_pkg.sv
// vector memory command and result types
// a strided command covers VLEN 32-bit elements, a load returns
// the gathered words in one result

`default_nettype none

package vmem_pkg;

  // elements per vector operation
  localparam int VLEN = 4;

  // one strided vector load or store
  typedef struct packed {
    // high for store, low for load
    logic                             store;
    bus_pkg::addr_t                   base;
    // signed byte distance between elements, wraps mod 2^32
    logic [31:0]                      stride;
    // store data, element i in data[i]
    bus_pkg::word_t [VLEN-1:0]        data;
  } vmem_cmd_t;

  // gathered load data, element i in data[i]
  typedef struct packed {
    bus_pkg::word_t [VLEN-1:0] data;
  } vmem_result_t;

endpackage

`default_nettype wire
